// ==== verilog/rvCore_params.svh ====
`ifndef RVCORE_PARAMS_SVH
`define RVCORE_PARAMS_SVH

// first fetch address after reset
`define RESET_PC 64'h0000_0000_0000_0000

// bus byte address width
`define MEM_AW 16

// bus data width
`define MEM_DW 64

`endif

// ==== verilog/rvCorePkg.sv ====
`include "rvCore_params.svh"

package rvCorePkg;

    typedef enum logic [6:0] {
        LOAD    = 7'b0000011,
        STORE   = 7'b0100011,
        BRANCH  = 7'b1100011,
        JAL     = 7'b1101111,
        JALR    = 7'b1100111,
        LUI     = 7'b0110111,
        AUIPC   = 7'b0010111,
        OPIMM   = 7'b0010011,
        OPIMM32 = 7'b0011011,
        OP      = 7'b0110011,
        OP32    = 7'b0111011
    } opcodeE;

    typedef enum logic [1:0] {
        IDLE,
        EXEC,
        MEMWAIT
    } coreStateE;

    typedef struct packed {
        logic                  valid;
        logic                  write;
        logic [7:0]            mask;
        logic [`MEM_AW-1:0]    addr;  // low 3 bits always zero
        logic [`MEM_DW-1:0]    wdata; // already in byte lanes
    } memReqT;

    typedef struct packed {
        logic        loadValid;
        logic        storeValid;
        logic [2:0]  funct3;
        logic [63:0] addr;
        logic [63:0] storeData;
    } lsReqT;

    typedef struct packed {
        opcodeE      opcode;
        logic [2:0]  funct3;
        logic [6:0]  funct7;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [63:0] immI;
        logic [63:0] immS;
        logic [63:0] immB;
        logic [63:0] immU;
        logic [63:0] immJ;
    } decodeT;

    typedef struct packed {
        logic        valid;
        logic [63:0] pc;
        logic [31:0] inst;
        logic        wen;
        logic [4:0]  rd;
        logic [63:0] wdata;
        logic [63:0] nextPc;
    } retireT;

endpackage

// ==== verilog/immDecode.sv ====
`timescale 1ns/10ps

module immDecode import rvCorePkg::*; (
    input  logic [31:0] inst,
    output decodeT      dec
);

    // undefined codes pass through and fall to the default arm in execute
    assign dec.opcode = opcodeE'(inst[6:0]);
    assign dec.rd     = inst[11:7];
    assign dec.funct3 = inst[14:12];
    assign dec.rs1    = inst[19:15];
    assign dec.rs2    = inst[24:20];
    assign dec.funct7 = inst[31:25];

    assign dec.immI = {{52{inst[31]}}, inst[31:20]};
    assign dec.immS = {{52{inst[31]}}, inst[31:25], inst[11:7]};
    assign dec.immB = {{51{inst[31]}}, inst[31], inst[7], inst[30:25],
                       inst[11:8], 1'b0};
    assign dec.immU = {{32{inst[31]}}, inst[31:12], 12'h000};
    assign dec.immJ = {{43{inst[31]}}, inst[31], inst[19:12], inst[20],
                       inst[30:21], 1'b0};

endmodule

// ==== verilog/regFile.sv ====
`timescale 1ns/10ps

module regFile (
    input  logic        clk,
    input  logic        arstN,
    input  logic        wen,
    input  logic [4:0]  waddr,
    input  logic [63:0] wdata,
    input  logic [4:0]  raddr1,
    input  logic [4:0]  raddr2,
    output logic [63:0] rdata1,
    output logic [63:0] rdata2
);

    logic [63:0] regs [1:31]; // x0 has no storage

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wen && (waddr != 5'd0)) begin
            regs[waddr] <= wdata;
        end
    end

    assign rdata1 = (raddr1 == 5'd0) ? 64'd0 : regs[raddr1];
    assign rdata2 = (raddr2 == 5'd0) ? 64'd0 : regs[raddr2];

endmodule

// ==== verilog/execUnit.sv ====
`timescale 1ns/10ps

module execUnit import rvCorePkg::*; (
    input  logic [63:0] pc,
    input  decodeT      dec,
    input  logic [63:0] rs1Val,
    input  logic [63:0] rs2Val,
    output logic        wen,
    output logic [63:0] wdata,
    output logic [63:0] nextPc,
    output lsReqT       lsReq
);

    logic [63:0] pcPlus4;
    logic        branchTaken;
    logic        immAlt;

    function automatic logic [63:0] alu64(input logic [2:0] f3, input logic alt,
                                          input logic [63:0] a, input logic [63:0] b);
        logic [63:0] res;
        case (f3)
            3'b000: res = alt ? a - b : a + b;
            3'b001: res = a << b[5:0];
            3'b010: res = {63'd0, $signed(a) < $signed(b)};
            3'b011: res = {63'd0, a < b};
            3'b100: res = a ^ b;
            3'b101: begin
                if (alt) begin
                    res = $signed(a) >>> b[5:0]; // sra
                end else begin
                    res = a >> b[5:0];
                end
            end
            3'b110: res = a | b;
            default: res = a & b;
        endcase
        return res;
    endfunction

    // word ops work on the low half and sign extend bit 31
    function automatic logic [63:0] alu32(input logic [2:0] f3, input logic alt,
                                          input logic [63:0] a, input logic [63:0] b);
        logic [31:0] res;
        case (f3)
            3'b000: res = alt ? a[31:0] - b[31:0] : a[31:0] + b[31:0];
            3'b001: res = a[31:0] << b[4:0];
            3'b101: begin
                if (alt) begin
                    res = $signed(a[31:0]) >>> b[4:0];
                end else begin
                    res = a[31:0] >> b[4:0];
                end
            end
            default: res = 32'd0;
        endcase
        return {{32{res[31]}}, res};
    endfunction

    assign pcPlus4 = pc + 64'd4;
    assign immAlt  = (dec.funct3 == 3'b101) && dec.funct7[5]; // only srai/sraiw

    always_comb begin
        case (dec.funct3)
            3'b000: branchTaken = (rs1Val == rs2Val);
            3'b001: branchTaken = (rs1Val != rs2Val);
            3'b100: branchTaken = ($signed(rs1Val) < $signed(rs2Val));
            3'b101: branchTaken = ($signed(rs1Val) >= $signed(rs2Val));
            3'b110: branchTaken = (rs1Val < rs2Val);
            3'b111: branchTaken = (rs1Val >= rs2Val);
            default: branchTaken = 1'b0;
        endcase
    end

    always_comb begin
        wen    = 1'b0;
        wdata  = '0;
        nextPc = pcPlus4;
        lsReq  = '0;
        case (dec.opcode)
            LUI: begin
                wen   = 1'b1;
                wdata = dec.immU;
            end
            AUIPC: begin
                wen   = 1'b1;
                wdata = pc + dec.immU;
            end
            JAL: begin
                wen    = 1'b1;
                wdata  = pcPlus4; // link
                nextPc = pc + dec.immJ;
            end
            JALR: begin
                wen    = 1'b1;
                wdata  = pcPlus4;
                nextPc = (rs1Val + dec.immI) & ~64'd1;
            end
            BRANCH: begin
                if (branchTaken) begin
                    nextPc = pc + dec.immB;
                end
            end
            LOAD: begin
                wen             = 1'b1; // data comes from the load unit
                lsReq.loadValid = 1'b1;
                lsReq.funct3    = dec.funct3;
                lsReq.addr      = rs1Val + dec.immI;
            end
            STORE: begin
                lsReq.storeValid = 1'b1;
                lsReq.funct3     = dec.funct3;
                lsReq.addr       = rs1Val + dec.immS;
                lsReq.storeData  = rs2Val;
            end
            OPIMM: begin
                wen   = 1'b1;
                wdata = alu64(dec.funct3, immAlt, rs1Val, dec.immI);
            end
            OPIMM32: begin
                wen   = 1'b1;
                wdata = alu32(dec.funct3, immAlt, rs1Val, dec.immI);
            end
            OP: begin
                wen   = 1'b1;
                wdata = alu64(dec.funct3, dec.funct7[5], rs1Val, rs2Val);
            end
            OP32: begin
                wen   = 1'b1;
                wdata = alu32(dec.funct3, dec.funct7[5], rs1Val, rs2Val);
            end
            default: begin
            end
        endcase
    end

endmodule

// ==== verilog/fetchUnit.sv ====
`timescale 1ns/10ps
`include "rvCore_params.svh"

module fetchUnit import rvCorePkg::*; (
    input  logic               clk,
    input  logic               arstN,
    output memReqT             fetchReq,
    input  logic               fetchGnt,
    input  logic               fetchRsp,
    input  logic [`MEM_DW-1:0] rspData,
    input  logic               instTake,
    input  logic               redirect,
    input  logic [63:0]        redirectPc,
    output logic               instValid,
    output logic [31:0]        inst,
    output logic [63:0]        instPc
);

    logic [63:0] fetchPc;
    logic [31:0] bufInst;
    logic        bufValid;
    logic        inFlight;
    logic        fetchEn;   // first request one cycle after reset release

    assign fetchReq.valid = fetchEn && !bufValid && !inFlight && !redirect;
    assign fetchReq.write = 1'b0;
    assign fetchReq.mask  = 8'h00;
    assign fetchReq.addr  = {fetchPc[`MEM_AW-1:3], 3'b000};
    assign fetchReq.wdata = '0;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            fetchPc  <= `RESET_PC;
            bufValid <= 1'b0;
            inFlight <= 1'b0;
            fetchEn  <= 1'b0;
        end else begin
            fetchEn <= 1'b1;
            if (fetchGnt) begin
                inFlight <= 1'b1;
            end else if (fetchRsp) begin
                inFlight <= 1'b0;
            end
            if (redirect) begin
                fetchPc  <= redirectPc;
                bufValid <= 1'b0;
            end else begin
                if (instTake) begin
                    fetchPc  <= fetchPc + 64'd4;
                    bufValid <= 1'b0;
                end
                if (fetchRsp) begin
                    bufValid <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (fetchRsp && !redirect) begin
            bufInst <= fetchPc[2] ? rspData[63:32] : rspData[31:0]; // half by pc bit 2
        end
    end

    assign instValid = bufValid;
    assign inst      = bufInst;
    assign instPc    = fetchPc;

endmodule

// ==== verilog/loadStoreUnit.sv ====
`timescale 1ns/10ps
`include "rvCore_params.svh"

module loadStoreUnit import rvCorePkg::*; (
    input  logic               clk,
    input  logic               arstN,
    input  lsReqT              lsReq,
    output memReqT             dataReq,
    input  logic               dataGnt,
    input  logic               dataRsp,
    input  logic [`MEM_DW-1:0] rspData,
    output logic [63:0]        loadData
);

    logic [2:0]  off;
    logic [7:0]  laneMask;
    logic [2:0]  ldFunct3;
    logic [2:0]  ldOff;
    logic [63:0] rspShift;
    logic [63:0] extended;

    assign off = lsReq.addr[2:0];

    always_comb begin
        case (lsReq.funct3[1:0])
            2'b00: laneMask = 8'h01 << off;
            2'b01: laneMask = 8'h03 << off;
            2'b10: laneMask = 8'h0f << off;
            default: laneMask = 8'hff;
        endcase
    end

    assign dataReq.valid = lsReq.loadValid | lsReq.storeValid;
    assign dataReq.write = lsReq.storeValid;
    assign dataReq.mask  = lsReq.storeValid ? laneMask : 8'h00;
    assign dataReq.addr  = {lsReq.addr[`MEM_AW-1:3], 3'b000};
    assign dataReq.wdata = lsReq.storeData << {off, 3'b000}; // into byte lanes

    // size and offset are needed again when the read returns
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            ldFunct3 <= 3'd0;
            ldOff    <= 3'd0;
        end else if (dataGnt && lsReq.loadValid) begin
            ldFunct3 <= lsReq.funct3;
            ldOff    <= off;
        end
    end

    assign rspShift = rspData >> {ldOff, 3'b000};

    always_comb begin
        case (ldFunct3)
            3'b000: extended = {{56{rspShift[7]}}, rspShift[7:0]};    // lb
            3'b001: extended = {{48{rspShift[15]}}, rspShift[15:0]};  // lh
            3'b010: extended = {{32{rspShift[31]}}, rspShift[31:0]};  // lw
            3'b100: extended = {56'd0, rspShift[7:0]};
            3'b101: extended = {48'd0, rspShift[15:0]};
            3'b110: extended = {32'd0, rspShift[31:0]};
            default: extended = rspShift;                            // ld
        endcase
    end

    assign loadData = dataRsp ? extended : 64'd0;

endmodule

// ==== verilog/memArbiter.sv ====
`timescale 1ns/10ps
`include "rvCore_params.svh"

module memArbiter import rvCorePkg::*; (
    input  logic               clk,
    input  logic               arstN,
    input  memReqT             fetchReq,
    input  memReqT             dataReq,
    output logic               fetchGnt,
    output logic               dataGnt,
    output memReqT             memReq,
    input  logic [`MEM_DW-1:0] memRdata,
    output logic               fetchRsp,
    output logic               dataRsp,
    output logic [`MEM_DW-1:0] rspData
);

    logic rdPending;
    logic rdOwnerData; // who issued last cycle's read

    // data side always wins
    assign dataGnt  = dataReq.valid;
    assign fetchGnt = fetchReq.valid && !dataReq.valid;
    assign memReq   = dataReq.valid ? dataReq : fetchReq;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            rdPending   <= 1'b0;
            rdOwnerData <= 1'b0;
        end else begin
            rdPending   <= memReq.valid && !memReq.write;
            rdOwnerData <= dataReq.valid;
        end
    end

    assign fetchRsp = rdPending && !rdOwnerData;
    assign dataRsp  = rdPending && rdOwnerData;
    assign rspData  = memRdata;

endmodule

// ==== verilog/rvCore.sv ====
`timescale 1ns/10ps
`include "rvCore_params.svh"

module rvCore import rvCorePkg::*; (
    input  logic               clk,
    input  logic               arstN,
    output memReqT             memReq,
    input  logic [`MEM_DW-1:0] memRdata,
    output retireT             retire
);

    coreStateE          state;
    logic [31:0]        curInst;
    logic [63:0]        curPc;
    decodeT             dec;
    logic [63:0]        rs1Val;
    logic [63:0]        rs2Val;
    logic               exWen;
    logic [63:0]        exWdata;
    logic [63:0]        exNextPc;
    lsReqT              lsReq;
    lsReqT              lsIssue;
    memReqT             fetchReq;
    memReqT             dataReq;
    logic               fetchGnt;
    logic               dataGnt;
    logic               fetchRsp;
    logic               dataRsp;
    logic [`MEM_DW-1:0] rspData;
    logic [63:0]        loadData;
    logic               instValid;
    logic [31:0]        inst;
    logic [63:0]        instPc;
    logic               execRetire;
    logic               loadGnt;
    logic               retireValid;
    logic               instTake;
    logic               redirect;
    logic [63:0]        rfWdata;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            state <= IDLE;
        end else begin
            case (state)
                IDLE:    if (instValid) state <= EXEC;
                EXEC:    if (loadGnt) state <= MEMWAIT; else if (execRetire) state <= IDLE;
                MEMWAIT: if (dataRsp) state <= IDLE;
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == IDLE && instValid) begin
            curInst <= inst;
            curPc   <= instPc;
        end
    end

    // bus requests only while the instruction is in EXEC
    always_comb begin
        lsIssue            = lsReq;
        lsIssue.loadValid  = lsReq.loadValid && (state == EXEC);
        lsIssue.storeValid = lsReq.storeValid && (state == EXEC);
    end

    assign loadGnt     = lsIssue.loadValid && dataGnt;
    assign execRetire  = (state == EXEC) && !lsReq.loadValid && (!lsReq.storeValid || dataGnt);
    assign retireValid = execRetire || ((state == MEMWAIT) && dataRsp);
    assign instTake    = execRetire || loadGnt; // frees the buffer for prefetch
    assign redirect    = execRetire && (exNextPc != curPc + 64'd4);
    assign rfWdata     = (state == MEMWAIT) ? loadData : exWdata;

    fetchUnit uFetch (
        .clk, .arstN, .fetchReq, .fetchGnt, .fetchRsp, .rspData,
        .instTake, .redirect, .redirectPc(exNextPc),
        .instValid, .inst, .instPc
    );

    loadStoreUnit uLsu (
        .clk, .arstN, .lsReq(lsIssue), .dataReq, .dataGnt, .dataRsp,
        .rspData, .loadData
    );

    memArbiter uArb (
        .clk, .arstN, .fetchReq, .dataReq, .fetchGnt, .dataGnt,
        .memReq, .memRdata, .fetchRsp, .dataRsp, .rspData
    );

    immDecode uDec (.inst(curInst), .dec);

    regFile uRegs (
        .clk, .arstN, .wen(retireValid && exWen), .waddr(dec.rd), .wdata(rfWdata),
        .raddr1(dec.rs1), .raddr2(dec.rs2), .rdata1(rs1Val), .rdata2(rs2Val)
    );

    execUnit uExec (
        .pc(curPc), .dec, .rs1Val, .rs2Val,
        .wen(exWen), .wdata(exWdata), .nextPc(exNextPc), .lsReq
    );

    assign retire.valid  = retireValid;
    assign retire.pc     = curPc;
    assign retire.inst   = curInst;
    assign retire.wen    = exWen;
    assign retire.rd     = dec.rd;
    assign retire.wdata  = rfWdata;
    assign retire.nextPc = exNextPc;

endmodule

// ==== tests/rvCore_checker.sv ====
`timescale 1ns/10ps

module rvCore_checker import rvCorePkg::*; (
    input logic   clk,
    input logic   arstN,
    input logic   fetchGnt,
    input logic   dataGnt,
    input memReqT memReq,
    input retireT retire
);

    int failCount = 0; // read by the testbench at the end

    gntExclusive: assert property (@(posedge clk) disable iff (!arstN)
        !(fetchGnt && dataGnt))
        else begin failCount++; $error("fetch and data granted together"); end

    quietInReset: assert property (@(posedge clk)
        !arstN |-> (!memReq.valid && !retire.valid))
        else begin failCount++; $error("bus or retire active during reset"); end

    addrAligned: assert property (@(posedge clk) disable iff (!arstN)
        memReq.valid |-> (memReq.addr[2:0] == 3'b000))
        else begin failCount++; $error("bus address not doubleword aligned"); end

    pcAligned: assert property (@(posedge clk) disable iff (!arstN)
        retire.valid |-> (retire.pc[1:0] == 2'b00))
        else begin failCount++; $error("retired pc not word aligned"); end

endmodule

bind rvCore rvCore_checker chk (.clk, .arstN, .fetchGnt, .dataGnt, .memReq, .retire);

// ==== tests/rvCoreMonitor.sv ====
`timescale 1ns/10ps
`include "rvCore_params.svh"

module rvCoreMonitor import rvCorePkg::*; (
    input  logic   clk,
    input  logic   arstN,
    input  memReqT memReq,
    input  retireT retire,
    output logic   done,
    output int     mismatches,
    output int     others
);

    logic [63:0] regs [0:31];
    logic [63:0] refMem [0:8191]; // loaded by the testbench before reset release
    logic [63:0] expPc;

    function automatic logic [63:0] aluRef(input logic word, input logic [2:0] f3,
                                           input logic alt, input logic [63:0] a,
                                           input logic [63:0] b);
        logic [63:0] r;
        logic [5:0]  sh;
        sh = word ? {1'b0, b[4:0]} : b[5:0];
        case (f3)
            3'd0: r = alt ? a - b : a + b;
            3'd1: r = a << sh;
            3'd2: r = ($signed(a) < $signed(b)) ? 64'd1 : 64'd0;
            3'd3: r = (a < b) ? 64'd1 : 64'd0;
            3'd4: r = a ^ b;
            3'd5: begin
                if (word) begin
                    r = alt ? 64'($signed({{32{a[31]}}, a[31:0]}) >>> sh)
                            : {32'd0, a[31:0]} >> sh;
                end else begin
                    r = alt ? 64'($signed(a) >>> sh) : a >> sh;
                end
            end
            3'd6: r = a | b;
            default: r = a & b;
        endcase
        if (word) begin
            r = {{32{r[31]}}, r[31:0]};
        end
        return r;
    endfunction

    task automatic compareField(input string name, input logic [63:0] got,
                                input logic [63:0] exp);
        if (got !== exp) begin
            mismatches++;
            $display("Mismatch %s: got %h expected %h at pc %h", name, got, exp, retire.pc);
        end
    endtask

    task automatic checkRetire();
        logic [31:0] inst;
        logic [6:0]  op;
        logic [2:0]  f3;
        logic [4:0]  rd;
        logic [63:0] a, b, immI, immS, immB, immJ, immU;
        logic [63:0] addr, word, lanes, byteMask, expWd, expNext;
        logic        expWen, taken, alt;
        logic [7:0]  mask;
        inst = expPc[2] ? refMem[expPc[15:3]][63:32] : refMem[expPc[15:3]][31:0];
        op = inst[6:0];
        f3 = inst[14:12];
        rd = inst[11:7];
        a = regs[inst[19:15]];
        b = regs[inst[24:20]];
        immI = 64'($signed(inst[31:20]));
        immS = 64'($signed({inst[31:25], inst[11:7]}));
        immB = 64'($signed({inst[31], inst[7], inst[30:25], inst[11:8], 1'b0}));
        immJ = 64'($signed({inst[31], inst[19:12], inst[20], inst[30:21], 1'b0}));
        immU = 64'($signed({inst[31:12], 12'h000}));
        expWen = 1'b0;
        expWd = '0;
        expNext = expPc + 64'd4;
        alt = inst[30] && (op[5] || f3 == 3'd5); // op[5] marks the register forms
        case (op)
            7'h37: begin
                expWen = 1'b1;
                expWd = immU;
            end
            7'h17: begin
                expWen = 1'b1;
                expWd = expPc + immU;
            end
            7'h6f: begin
                expWen = 1'b1;
                expWd = expNext;
                expNext = expPc + immJ;
            end
            7'h67: begin
                expWen = 1'b1;
                expWd = expNext;
                expNext = (a + immI) & ~64'd1;
            end
            7'h63: begin
                case (f3)
                    3'd0: taken = (a == b);
                    3'd1: taken = (a != b);
                    3'd4: taken = $signed(a) < $signed(b);
                    3'd5: taken = $signed(a) >= $signed(b);
                    3'd6: taken = a < b;
                    default: taken = a >= b;
                endcase
                if (taken) expNext = expPc + immB;
            end
            7'h03: begin
                expWen = 1'b1;
                addr = a + immI;
                word = refMem[addr[15:3]] >> (8 * addr[2:0]);
                case (f3)
                    3'd0: expWd = 64'($signed(word[7:0]));
                    3'd1: expWd = 64'($signed(word[15:0]));
                    3'd2: expWd = 64'($signed(word[31:0]));
                    3'd4: expWd = {56'd0, word[7:0]};
                    3'd5: expWd = {48'd0, word[15:0]};
                    3'd6: expWd = {32'd0, word[31:0]};
                    default: expWd = word;
                endcase
            end
            7'h23: begin
                addr = a + immS;
                mask = 8'((1 << (1 << f3[1:0])) - 1) << addr[2:0];
                lanes = b << (8 * addr[2:0]);
                for (int k = 0; k < 8; k++) begin
                    byteMask[8*k +: 8] = {8{mask[k]}};
                end
                if (!(memReq.valid && memReq.write)) begin
                    others++;
                    $display("store at pc %h drove no bus write", retire.pc);
                end else begin
                    compareField("memReq.addr", 64'(memReq.addr), {48'd0, addr[15:3], 3'b000});
                    compareField("memReq.mask", 64'(memReq.mask), 64'(mask));
                    compareField("memReq.wdata", memReq.wdata & byteMask, lanes & byteMask);
                end
                refMem[addr[15:3]] = (refMem[addr[15:3]] & ~byteMask) | (lanes & byteMask);
            end
            7'h13: begin
                expWen = 1'b1;
                expWd = aluRef(1'b0, f3, alt, a, immI);
            end
            7'h1b: begin
                expWen = 1'b1;
                expWd = aluRef(1'b1, f3, alt, a, immI);
            end
            7'h33: begin
                expWen = 1'b1;
                expWd = aluRef(1'b0, f3, alt, a, b);
            end
            7'h3b: begin
                expWen = 1'b1;
                expWd = aluRef(1'b1, f3, alt, a, b);
            end
            default: begin
            end
        endcase
        compareField("retire.pc", retire.pc, expPc);
        compareField("retire.inst", 64'(retire.inst), 64'(inst));
        compareField("retire.wen", 64'(retire.wen), 64'(expWen));
        if (expWen) begin
            compareField("retire.rd", 64'(retire.rd), 64'(rd));
            compareField("retire.wdata", retire.wdata, expWd);
        end
        compareField("retire.nextPc", retire.nextPc, expNext);
        if (expWen && rd != 5'd0) regs[rd] = expWd;
        expPc = expNext;
        if (inst == 32'h0000_006f) done = 1'b1; // final self loop
    endtask

    initial begin
        mismatches = 0;
        others = 0;
        done = 1'b0;
    end

    always @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            expPc = `RESET_PC;
            for (int i = 0; i < 32; i++) regs[i] = '0;
        end else if (retire.valid && !done) begin
            checkRetire();
        end
    end

endmodule

// ==== tests/rvCoreTb.sv ====
`timescale 1ns/10ps
`include "rvCore_params.svh"

module rvCoreTb import rvCorePkg::*; ();

    localparam int NumInst = 128;
    localparam int TimeLimit = NumInst * 4 * 40 * 4; // ns

    logic               clk;
    logic               arstN;
    memReqT             memReq;
    logic [`MEM_DW-1:0] memRdata;
    retireT             retire;
    logic [63:0]        mem [0:8191];
    logic [31:0]        prog [0:NumInst-1];
    logic               rdPend;
    logic [12:0]        rdWord;
    logic               done;
    int                 mismatches;
    int                 others;
    logic [31:0]        lfsr = 32'ha558_c275;

    rvCore i_rvCore (.clk, .arstN, .memReq, .memRdata, .retire);

    rvCoreMonitor uMonitor (.clk, .arstN, .memReq, .retire, .done, .mismatches, .others);

    // one lfsr step per bit, taps 32 22 2 1
    function automatic logic [31:0] randBits(input int n);
        logic [31:0] r;
        logic        fb;
        r = '0;
        for (int i = 0; i < n; i++) begin
            fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            r = {r[30:0], fb};
        end
        return r;
    endfunction

    function automatic int fwdTarget(input int i);
        int t;
        t = i + 1 + int'(randBits(3));
        return (t > NumInst - 1) ? NumInst - 1 : t;
    endfunction

    function automatic logic [31:0] genInst(input int i);
        logic [4:0]  rd, rs1, rs2;
        logic [2:0]  f3;
        logic        alt;
        logic [11:0] imm;
        logic [12:0] bOff;
        logic [20:0] jOff;
        int          t;
        rd = 5'(2 + randBits(5) % 30); // x1 stays the data base
        rs1 = 5'(randBits(5));
        rs2 = 5'(randBits(5));
        f3 = 3'(randBits(3));
        alt = randBits(1) == 1;
        imm = 12'(randBits(12));
        case (randBits(4))
            0, 1, 2: return {1'b0, alt && (f3 == 0 || f3 == 5), 5'd0, rs2, rs1, f3, rd, 7'h33};
            3, 4: begin
                if (f3 == 3'd1) imm = {6'd0, imm[5:0]};
                if (f3 == 3'd5) imm = {1'b0, alt, 4'd0, imm[5:0]};
                return {imm, rs1, f3, rd, 7'h13};
            end
            5: begin
                f3 = (f3 < 3) ? 3'd0 : ((f3 < 5) ? 3'd1 : 3'd5);
                return {1'b0, alt && f3 != 3'd1, 5'd0, rs2, rs1, f3, rd, 7'h3b};
            end
            6: begin
                f3 = (f3 < 3) ? 3'd0 : ((f3 < 5) ? 3'd1 : 3'd5);
                if (f3 != 3'd0) imm = {1'b0, alt && f3 == 3'd5, 5'd0, imm[4:0]};
                return {imm, rs1, f3, rd, 7'h1b};
            end
            7: return {20'(randBits(20)), rd, alt ? 7'h37 : 7'h17};
            8, 9: begin
                f3 = 3'(randBits(3) % 7);
                imm = 12'(randBits(8) << f3[1:0]); // size aligned
                return {imm, 5'd1, f3, rd, 7'h03};
            end
            10: begin
                f3 = {1'b0, f3[1:0]};
                imm = 12'(randBits(8) << f3[1:0]);
                return {imm[11:5], rs2, 5'd1, f3, imm[4:0], 7'h23};
            end
            12: begin
                jOff = 21'((fwdTarget(i) - i) * 4);
                return {jOff[20], jOff[10:1], jOff[11], jOff[19:12], rd, 7'h6f};
            end
            13: begin
                t = fwdTarget(i);
                return {12'(t * 4), 5'd0, 3'd0, rd, 7'h67};
            end
            default: begin
                if (f3 == 3'd2 || f3 == 3'd3) f3 = {2'b11, f3[0]};
                bOff = 13'((fwdTarget(i) - i) * 4);
                return {bOff[12], bOff[10:5], rs2, rs1, f3, bOff[4:1], bOff[11], 7'h63};
            end
        endcase
    endfunction

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // bus model: writes land at the edge, read data follows a cycle later
    always @(posedge clk) begin
        rdPend <= arstN && memReq.valid && !memReq.write;
        rdWord <= memReq.addr[15:3];
        if (arstN && memReq.valid && memReq.write) begin
            for (int k = 0; k < 8; k++) begin
                if (memReq.mask[k]) mem[memReq.addr[15:3]][8*k +: 8] <= memReq.wdata[8*k +: 8];
            end
        end
    end

    always @(negedge clk) begin
        memRdata <= rdPend ? mem[rdWord] : '0;
    end

    initial begin
        arstN = 1'b0;
        memRdata = '0;
        rdPend = 1'b0;
        rdWord = '0;
        for (int w = 0; w < 8192; w++) begin
            mem[w] = {w[15:0] ^ 16'h5a5a, 16'(w * 3), ~w[15:0], 16'(w + 16'h1234)};
        end
        prog[0] = {20'h00008, 5'd1, 7'h37}; // lui x1 -> 0x8000
        for (int i = 1; i < NumInst - 1; i++) prog[i] = genInst(i);
        prog[NumInst-1] = 32'h0000_006f;
        for (int i = 0; i < NumInst; i += 2) mem[i/2] = {prog[i+1], prog[i]};
        for (int w = 0; w < 8192; w++) uMonitor.refMem[w] = mem[w];
        repeat (3) @(negedge clk);
        arstN = 1'b1;
        wait (done);
        @(negedge clk);
        $display("errors: %0d mismatches, %0d other, %0d assertion failures",
                 mismatches, others, i_rvCore.chk.failCount);
        if (mismatches == 0 && others == 0 && i_rvCore.chk.failCount == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

    initial begin
        #(TimeLimit);
        $display("program did not finish within %0d ns", TimeLimit);
        $display("errors: %0d mismatches, %0d other, %0d assertion failures",
                 mismatches, others + 1, i_rvCore.chk.failCount);
        $display("sim failed");
        $finish;
    end

endmodule

// ==== rvCore.f ====
+incdir+verilog
verilog/rvCorePkg.sv
verilog/immDecode.sv
verilog/regFile.sv
verilog/execUnit.sv
verilog/fetchUnit.sv
verilog/loadStoreUnit.sv
verilog/memArbiter.sv
verilog/rvCore.sv
tests/rvCore_checker.sv
tests/rvCoreMonitor.sv
tests/rvCoreTb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= rvCoreTb
FILELIST  ?= rvCore.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
RUNFLAGS  ?= +verilator+error+limit+1000

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR) -o $(TOP)
	./$(BUILD_DIR)/$(TOP) $(RUNFLAGS) | tee $(LOG)
	grep -q "sim passed" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
